// ==== sources.f ====
logic/wh_router_pkg.sv
logic/wh_alloc_if.sv
logic/wh_input_fifo.sv
logic/wh_input_control.sv
logic/wh_round_robin_arb.sv
logic/wh_output_control.sv
logic/wh_router.sv
tb/wh_router_assertions.sv
tb/wh_router_tb.sv

// ==== Makefile ====
# Verilator build for the wormhole router testbench

VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= wh_router_tb
FILELIST  ?= sources.f
OBJ_DIR   ?= obj_dir

SIM_BIN   := $(OBJ_DIR)/V$(TOP)
SOURCES   := $(shell cat $(FILELIST))

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# exit status of the simulation is the pass or fail result
run: compile
	./$(SIM_BIN)

clean:
	rm -rf $(OBJ_DIR)

// ==== tb/wh_router_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module wh_router_tb
   import wh_router_pkg::*;
();

   localparam int rand_pkts_c = 30;
   localparam int fair_pkts_c = 8;
   localparam int fifo_els_c  = 2;
   // 200 cycles for every packet the run sends
   localparam int timeout_cycles_c = 200 * (num_dirs_c * rand_pkts_c + 2 * fair_pkts_c);

   logic                   clk;
   logic                   reset;
   cord_t                  my_cord;
   dirs_t                  in_valid;
   flit_t [num_dirs_c-1:0] in_data;
   dirs_t                  in_ready;
   dirs_t                  out_valid;
   flit_t [num_dirs_c-1:0] out_data;
   dirs_t                  out_ready;

   int    seed = 32'h28fe5ea4;
   logic  stall_en;
   logic  fair_mode;

   // expected flits indexed by source * num_dirs_c + output
   flit_t exp_q [num_dirs_c * num_dirs_c][$];

   // per output wormhole tracking owned by the checker
   int    body_left [num_dirs_c] = '{default: 0};
   int    cur_src [num_dirs_c] = '{default: 0};
   int    last_fair_src = -1;
   dirs_t stall_pend = '0;
   flit_t stall_flit [num_dirs_c];
   // flits accepted by each input and not yet sent out
   int    fifo_occ [num_dirs_c] = '{default: 0};

   wh_router #(
      .hold_on_valid_p (1'b0),
      .fifo_els_p      (fifo_els_c)
   ) dut_i (
      .clk_i        (clk),
      .reset_i      (reset),
      .my_cord_i    (my_cord),
      .link_valid_i (in_valid),
      .link_data_i  (in_data),
      .link_ready_o (in_ready),
      .link_valid_o (out_valid),
      .link_data_o  (out_data),
      .link_ready_i (out_ready)
   );

   initial begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   // dimension order routing on one axis
   function automatic dir_e exp_dir(input cord_t dest, input cord_t here);
      if (dest < here) begin
         return dir_w;
      end else if (dest > here) begin
         return dir_east;
      end
      return dir_p;
   endfunction

   function automatic int pending_flits();
      int n;
      n = 0;
      for (int k = 0; k < num_dirs_c * num_dirs_c; k++) begin
         n = n + exp_q[k].size();
      end
      return n;
   endfunction

   task automatic fail_now(input string msg);
      $display("FAIL at time %0t: %s", $time, msg);
      $display("TEST FAIL");
      $fatal(1, "stopped at the first error");
   endtask

   // header, then len body flits; every flit names its source and sequence
   task automatic send_packet(input int src, input cord_t dest, input len_t len, input int seq);
      flit_t f;
      int    out;
      out = int'(exp_dir(dest, my_cord));
      for (int n = 0; n <= int'(len); n++) begin
         if (n == 0) begin
            f = {src[1:0], seq[5:0], len, dest};
         end else begin
            f = {src[1:0], seq[5:0], 8'(n)};
         end
         exp_q[src * num_dirs_c + out].push_back(f);
         @(negedge clk);
         in_valid[src] = 1'b1;
         in_data[src]  = f;
         // ready only moves on the rising edge so it is stable here
         while (!in_ready[src]) begin
            @(negedge clk);
         end
      end
   endtask

   task automatic idle_link(input int src, input int cycles);
      for (int c = 0; c < cycles; c++) begin
         @(negedge clk);
         in_valid[src] = 1'b0;
      end
   endtask

   task automatic stream_random(input int src);
      cord_t dest;
      len_t  len;
      for (int p = 0; p < rand_pkts_c; p++) begin
         // destinations around this node so all three outputs see traffic
         dest = cord_t'(int'(my_cord) - 3 + int'($unsigned($random(seed)) % 7));
         len  = len_t'($unsigned($random(seed)) % 6);
         send_packet(src, dest, len, p);
         idle_link(src, int'($unsigned($random(seed)) % 3));
      end
      idle_link(src, 1);
   endtask

   // back to back packets to the local port
   task automatic stream_fair(input int src);
      for (int p = 0; p < fair_pkts_c; p++) begin
         send_packet(src, my_cord, len_t'($unsigned($random(seed)) % 4), 32 + p);
      end
      idle_link(src, 1);
   endtask

   task automatic drain(input int max_cycles);
      int n;
      n = 0;
      while (pending_flits() != 0 && n < max_cycles) begin
         @(negedge clk);
         n++;
      end
   endtask

   task automatic check_flit(input int o, input flit_t f);
      int s;
      int idx;
      s = int'(f[15:14]);
      assert (s < num_dirs_c)
         else fail_now($sformatf("output %0d sent flit %h with no valid source", o, f));
      idx = s * num_dirs_c + o;
      if (body_left[o] > 0) begin
         // inside a packet the worm must not be cut by another source
         assert (s == cur_src[o])
            else fail_now($sformatf("output %0d mixed source %0d into packet of %0d",
                                    o, s, cur_src[o]));
         body_left[o]--;
      end else begin
         assert (int'(exp_dir(f[3:0], my_cord)) == o)
            else fail_now($sformatf("header %h left on wrong output %0d", f, o));
         cur_src[o]   = s;
         body_left[o] = int'(f[7:4]);
         if (fair_mode && o == int'(dir_p)) begin
            assert (s != last_fair_src)
               else fail_now($sformatf("source %0d won the local port twice in a row", s));
            last_fair_src = s;
         end
      end
      assert (exp_q[idx].size() > 0)
         else fail_now($sformatf("output %0d sent unexpected flit %h", o, f));
      assert (f == exp_q[idx][0])
         else fail_now($sformatf("output %0d sent %h, expected %h", o, f, exp_q[idx][0]));
      void'(exp_q[idx].pop_front());
   endtask

   // outputs are sampled on the rising edge before the design updates
   always @(posedge clk) begin
      if (!fair_mode) begin
         last_fair_src = -1;
      end
      if (!reset) begin
         // an input refuses only while every fifo entry holds a flit
         for (int i = 0; i < num_dirs_c; i++) begin
            assert (in_ready[i] == (fifo_occ[i] < fifo_els_c))
               else fail_now($sformatf("input %0d ready %b with %0d flits queued",
                                       i, in_ready[i], fifo_occ[i]));
            if (in_valid[i] && in_ready[i]) begin
               fifo_occ[i]++;
            end
         end
         for (int o = 0; o < num_dirs_c; o++) begin
            // a stalled flit must still be offered unchanged
            if (stall_pend[o]) begin
               assert (out_valid[o] && out_data[o] == stall_flit[o])
                  else fail_now($sformatf("stalled flit on output %0d changed", o));
            end
            stall_pend[o] = out_valid[o] && !out_ready[o];
            stall_flit[o] = out_data[o];
            if (out_valid[o] && out_ready[o]) begin
               check_flit(o, out_data[o]);
               fifo_occ[int'(out_data[o][15:14])]--;
            end
         end
      end
   end

   // outputs stall at random only while stall_en is set
   initial begin
      out_ready = '1;
      forever begin
         @(negedge clk);
         for (int o = 0; o < num_dirs_c; o++) begin
            if (stall_en) begin
               out_ready[o] = (($unsigned($random(seed)) % 4) != 0);
            end else begin
               out_ready[o] = 1'b1;
            end
         end
      end
   end

   initial begin
      repeat (timeout_cycles_c + 16) @(posedge clk);
      $display("watchdog expired, traffic did not finish in %0d cycles", timeout_cycles_c);
      $display("TEST FAIL");
      $fatal(1, "timeout");
   end

   initial begin
      reset     = 1'b1;
      my_cord   = 4'd6;
      in_valid  = '0;
      in_data   = '0;
      stall_en  = 1'b0;
      fair_mode = 1'b0;
      repeat (16) begin
         @(negedge clk);
         assert (out_valid == '0)
            else fail_now($sformatf("link valid %b during reset", out_valid));
      end
      reset = 1'b0;
      @(negedge clk);
      assert (out_valid == '0)
         else fail_now($sformatf("link valid %b right after reset", out_valid));

      // all inputs at once with output stalls
      stall_en = 1'b1;
      fork
         stream_random(int'(dir_p));
         stream_random(int'(dir_w));
         stream_random(int'(dir_east));
      join
      drain(2000);

      // two sources fighting for the local port
      stall_en  = 1'b0;
      fair_mode = 1'b1;
      fork
         stream_fair(int'(dir_w));
         stream_fair(int'(dir_east));
      join
      drain(2000);

      if (pending_flits() == 0) begin
         $display("TEST PASS");
         $finish;
      end else begin
         $display("%0d expected flits never left the router", pending_flits());
         $display("TEST FAIL");
         $fatal(1, "undelivered flits");
      end
   end

endmodule

`default_nettype wire

// ==== tb/wh_router_assertions.sv ====
`timescale 1ns/1ps
`default_nettype none

module wh_router_assertions
   import wh_router_pkg::*;
(
   input logic  clk_i,
   input logic  reset_i,
   input logic  link_ready_i,
   input dirs_t data_sel_i,
   input dirs_t yumi_i,
   input dirs_t releases_i,
   input dirs_t scheduled_i
);

   // the crossbar leg ORs heads together so two selects would corrupt data
   sel_onehot: assert property (@(posedge clk_i) disable iff (reset_i)
      $onehot0(data_sel_i))
      else $error("data select has more than one input picked");

   // every head stays put while the link stalls
   no_yumi_stall: assert property (@(posedge clk_i) disable iff (reset_i)
      !link_ready_i |-> yumi_i == '0)
      else $error("input popped while the output link was stalled");

   // only the input holding the output may release it
   release_owner: assert property (@(posedge clk_i) disable iff (reset_i)
      |releases_i |-> (releases_i & ~scheduled_i) == '0)
      else $error("release from an input that was not scheduled");

endmodule

bind wh_output_control wh_router_assertions asrt_i (
   .clk_i        (clk_i),
   .reset_i      (reset_i),
   .link_ready_i (link_ready_i),
   .data_sel_i   (data_sel_o),
   .yumi_i       (alloc.yumi),
   .releases_i   (alloc.releases),
   .scheduled_i  (scheduled_r)
);

`default_nettype wire

// ==== logic/wh_router.sv ====
`timescale 1ns/1ps
`default_nettype none

module wh_router
   import wh_router_pkg::*;
#(
   parameter bit hold_on_valid_p = 1'b0,
   parameter int fifo_els_p      = 2
) (
   input  logic                   clk_i,
   input  logic                   reset_i,

   // tied off per tile
   input  cord_t                  my_cord_i,

   // input links, indexed by dir_e
   input  dirs_t                  link_valid_i,
   input  flit_t [num_dirs_c-1:0] link_data_i,
   output dirs_t                  link_ready_o,

   // output links, indexed by dir_e
   output dirs_t                  link_valid_o,
   output flit_t [num_dirs_c-1:0] link_data_o,
   input  dirs_t                  link_ready_i
);

   // per input fifo heads
   dirs_t fifo_valid;
   flit_t fifo_data [num_dirs_c];
   dirs_t fifo_yumi;

   // indexed [input][output] as produced by the controllers
   dirs_t reqs_in [num_dirs_c];
   dirs_t rels_in [num_dirs_c];
   // indexed [output][input] as seen by the allocators
   dirs_t reqs_out [num_dirs_c];
   dirs_t rels_out [num_dirs_c];
   dirs_t yumi_out [num_dirs_c];
   dirs_t sel_out  [num_dirs_c];

   for (genvar i = 0; i < num_dirs_c; i++) begin : g_in
      wh_input_fifo #(
         .els_p (fifo_els_p)
      ) fifo_i (
         .clk_i        (clk_i),
         .reset_i      (reset_i),
         .enq_valid_i  (link_valid_i[i]),
         .enq_data_i   (link_data_i[i]),
         .enq_ready_o  (link_ready_o[i]),
         .fifo_valid_o (fifo_valid[i]),
         .fifo_data_o  (fifo_data[i]),
         .fifo_yumi_i  (fifo_yumi[i])
      );

      wh_input_control ctrl_i (
         .clk_i        (clk_i),
         .reset_i      (reset_i),
         .my_cord_i    (my_cord_i),
         .fifo_valid_i (fifo_valid[i]),
         .fifo_data_i  (fifo_data[i]),
         .fifo_yumi_i  (fifo_yumi[i]),
         .reqs_o       (reqs_in[i]),
         .release_o    (rels_in[i])
      );
   end

   // transpose input-major into output-major, and merge yumis back per input
   always_comb begin
      fifo_yumi = '0;
      for (int o = 0; o < num_dirs_c; o++) begin
         for (int i = 0; i < num_dirs_c; i++) begin
            reqs_out[o][i] = reqs_in[i][o];
            rels_out[o][i] = rels_in[i][o];
            // only the allocated output can pop, so the OR never collides
            fifo_yumi[i]   = fifo_yumi[i] | yumi_out[o][i];
         end
      end
   end

   for (genvar o = 0; o < num_dirs_c; o++) begin : g_out
      wh_alloc_if alloc ();

      assign alloc.reqs     = reqs_out[o];
      assign alloc.releases = rels_out[o];
      assign alloc.valid    = fifo_valid;
      assign yumi_out[o]    = alloc.yumi;

      wh_output_control #(
         .hold_on_valid_p (hold_on_valid_p)
      ) octl_i (
         .clk_i        (clk_i),
         .reset_i      (reset_i),
         .alloc        (alloc),
         .link_ready_i (link_ready_i[o]),
         .link_valid_o (link_valid_o[o]),
         .data_sel_o   (sel_out[o])
      );

      // and-or crossbar leg, select is one-hot or zero
      always_comb begin
         link_data_o[o] = '0;
         for (int i = 0; i < num_dirs_c; i++) begin
            link_data_o[o] = link_data_o[o] | ({$bits(flit_t){sel_out[o][i]}} & fifo_data[i]);
         end
      end
   end

endmodule

`default_nettype wire

// ==== logic/wh_output_control.sv ====
`timescale 1ns/1ps
`default_nettype none

module wh_output_control
   import wh_router_pkg::*;
#(
   parameter bit hold_on_valid_p = 1'b0
) (
   input  logic          clk_i,
   input  logic          reset_i,

   wh_alloc_if.out_ctrl  alloc,

   // output link
   input  logic          link_ready_i,
   output logic          link_valid_o,
   // one-hot crossbar select, zero when idle
   output dirs_t         data_sel_o
);

   dirs_t scheduled_r;
   dirs_t sched_with_rel;
   dirs_t scheduled_n;
   dirs_t grants_lo;
   logic  free_to_schedule;
   logic  arb_yumi;

   // releases refer to the previous cycle, so they mask the register
   assign sched_with_rel   = scheduled_r & ~alloc.releases;
   assign free_to_schedule = ~|sched_with_rel;

   // pointer only moves once a header has really gone out
   assign arb_yumi = free_to_schedule & link_ready_i & link_valid_o;

   wh_round_robin_arb #(
      .num_reqs_p      (num_dirs_c),
      .hold_on_valid_p (hold_on_valid_p)
   ) arb_i (
      .clk_i       (clk_i),
      .reset_i     (reset_i),
      .grants_en_i (free_to_schedule),
      .reqs_i      (alloc.reqs),
      .grants_o    (grants_lo),
      .yumi_i      (arb_yumi)
   );

   // a fresh grant counts as scheduled in the same cycle
   assign scheduled_n = grants_lo | sched_with_rel;

   always_ff @(posedge clk_i) begin
      if (reset_i) begin
         scheduled_r <= '0;
      end else begin
         scheduled_r <= scheduled_n;
      end
   end

   assign data_sel_o   = scheduled_n;
   assign link_valid_o = |(scheduled_n & alloc.valid);
   // no pop while the link stalls, the flit waits at the fifo head
   assign alloc.yumi   = link_ready_i ? (scheduled_n & alloc.valid) : '0;

endmodule

`default_nettype wire

// ==== logic/wh_round_robin_arb.sv ====
`timescale 1ns/1ps
`default_nettype none

module wh_round_robin_arb #(
   parameter int num_reqs_p      = 3,
   parameter bit hold_on_valid_p = 1'b0
) (
   input  logic                  clk_i,
   input  logic                  reset_i,

   // no grant is issued while low
   input  logic                  grants_en_i,
   input  logic [num_reqs_p-1:0] reqs_i,
   output logic [num_reqs_p-1:0] grants_o,

   // current grant was taken, rotate priority past it
   input  logic                  yumi_i
);

   localparam int idx_w_lp = (num_reqs_p > 1) ? $clog2(num_reqs_p) : 1;

   logic [idx_w_lp-1:0]   ptr_r;
   logic [num_reqs_p-1:0] pick;
   logic [num_reqs_p-1:0] hold_r;
   logic [num_reqs_p-1:0] grant_raw;
   logic [idx_w_lp-1:0]   gnt_idx;

   // first requester at or after the pointer, wrapping around
   always_comb begin
      int  j;
      logic found;
      pick  = '0;
      found = 1'b0;
      for (int k = 0; k < num_reqs_p; k++) begin
         j = int'(ptr_r) + k;
         if (j >= num_reqs_p) begin
            j = j - num_reqs_p;
         end
         if (reqs_i[j] && !found) begin
            pick[j] = 1'b1;
            found   = 1'b1;
         end
      end
   end

   // a held grant wins as long as its requester keeps asking
   always_comb begin
      if (hold_on_valid_p && |(hold_r & reqs_i)) begin
         grant_raw = hold_r & reqs_i;
      end else begin
         grant_raw = pick;
      end
   end

   assign grants_o = grants_en_i ? grant_raw : '0;

   // index of the winner, for the pointer update
   always_comb begin
      gnt_idx = '0;
      for (int k = 0; k < num_reqs_p; k++) begin
         if (grants_o[k]) begin
            gnt_idx = idx_w_lp'(k);
         end
      end
   end

   always_ff @(posedge clk_i) begin
      if (reset_i) begin
         ptr_r  <= '0;
         hold_r <= '0;
      end else begin
         if (yumi_i && |grants_o) begin
            ptr_r <= (gnt_idx == idx_w_lp'(num_reqs_p - 1)) ? '0 : gnt_idx + 1'b1;
         end
         // keep an untaken grant, drop it once taken or once disabled
         if (hold_on_valid_p && grants_en_i && !yumi_i) begin
            hold_r <= grants_o;
         end else begin
            hold_r <= '0;
         end
      end
   end

endmodule

`default_nettype wire

// ==== logic/wh_input_control.sv ====
`timescale 1ns/1ps
`default_nettype none

module wh_input_control
   import wh_router_pkg::*;
(
   input  logic  clk_i,
   input  logic  reset_i,

   input  cord_t my_cord_i,

   // head of this input's fifo
   input  logic  fifo_valid_i,
   input  flit_t fifo_data_i,
   // OR of all outputs' yumi for this input
   input  logic  fifo_yumi_i,

   // one-hot request toward the routed output
   output dirs_t reqs_o,
   // one-hot pulse, the packet finished on the previous cycle
   output dirs_t release_o
);

   ictl_state_e state_r;
   dirs_t       route_dirs;
   dirs_t       out_dirs_r;
   dirs_t       release_r;
   len_t        count_r;
   cord_t       dest_cord;
   len_t        pkt_len;
   logic        last_yumi;

   // fields only mean something while idle, head is then a header
   assign dest_cord = hdr_cord(fifo_data_i);
   assign pkt_len   = hdr_len(fifo_data_i);

   // dimension routing, lower goes west, higher goes east
   always_comb begin
      route_dirs = '0;
      if (dest_cord < my_cord_i) begin
         route_dirs[dir_w] = 1'b1;
      end else if (dest_cord > my_cord_i) begin
         route_dirs[dir_east] = 1'b1;
      end else begin
         route_dirs[dir_p] = 1'b1;
      end
   end

   // request held until the header is popped
   assign reqs_o = (state_r == ictl_idle && fifo_valid_i) ? route_dirs : '0;

   // header-only packet, or the final body flit
   assign last_yumi = fifo_yumi_i &&
                      ((state_r == ictl_idle && pkt_len == '0) ||
                       (state_r == ictl_busy && count_r == len_t'(1)));

   always_ff @(posedge clk_i) begin
      if (reset_i) begin
         state_r    <= ictl_idle;
         count_r    <= '0;
         out_dirs_r <= '0;
         release_r  <= '0;
      end else begin
         // release goes to whichever output carried the packet
         if (last_yumi) begin
            release_r <= (state_r == ictl_idle) ? route_dirs : out_dirs_r;
         end else begin
            release_r <= '0;
         end

         if (fifo_yumi_i) begin
            case (state_r)
               ictl_idle: begin
                  // header leaving, remember the route while the body streams
                  if (pkt_len != '0) begin
                     state_r    <= ictl_busy;
                     count_r    <= pkt_len;
                     out_dirs_r <= route_dirs;
                  end
               end
               ictl_busy: begin
                  count_r <= count_r - 1'b1;
                  if (count_r == len_t'(1)) begin
                     state_r <= ictl_idle;
                  end
               end
               default: state_r <= ictl_idle;
            endcase
         end
      end
   end

   assign release_o = release_r;

endmodule

`default_nettype wire

// ==== logic/wh_input_fifo.sv ====
`timescale 1ns/1ps
`default_nettype none

module wh_input_fifo
   import wh_router_pkg::*;
#(
   parameter int els_p = 2
) (
   input  logic  clk_i,
   input  logic  reset_i,

   // link side, valid/ready
   input  logic  enq_valid_i,
   input  flit_t enq_data_i,
   output logic  enq_ready_o,

   // router side, valid/yumi
   output logic  fifo_valid_o,
   output flit_t fifo_data_o,
   input  logic  fifo_yumi_i
);

   localparam int ptr_w_lp = (els_p > 1) ? $clog2(els_p) : 1;
   localparam int cnt_w_lp = $clog2(els_p + 1);

   flit_t                mem_r [els_p];
   logic [ptr_w_lp-1:0]  wptr_r, rptr_r;
   logic [cnt_w_lp-1:0]  count_r;
   logic                 enq, deq;

   // only refuse while every entry is occupied
   assign enq_ready_o  = (count_r != cnt_w_lp'(els_p));
   assign fifo_valid_o = (count_r != '0);
   assign fifo_data_o  = mem_r[rptr_r];

   assign enq = enq_valid_i & enq_ready_o;
   // yumi is only legal with valid high, mask anyway
   assign deq = fifo_yumi_i & fifo_valid_o;

   // storage, no reset needed
   always_ff @(posedge clk_i) begin
      if (enq) begin
         mem_r[wptr_r] <= enq_data_i;
      end
   end

   always_ff @(posedge clk_i) begin
      if (reset_i) begin
         wptr_r  <= '0;
         rptr_r  <= '0;
         count_r <= '0;
      end else begin
         if (enq) begin
            wptr_r <= (wptr_r == ptr_w_lp'(els_p - 1)) ? '0 : wptr_r + 1'b1;
         end
         if (deq) begin
            rptr_r <= (rptr_r == ptr_w_lp'(els_p - 1)) ? '0 : rptr_r + 1'b1;
         end
         // simultaneous enq and deq leave the count alone
         if (enq && !deq) begin
            count_r <= count_r + 1'b1;
         end else if (!enq && deq) begin
            count_r <= count_r - 1'b1;
         end
      end
   end

endmodule

`default_nettype wire

// ==== logic/wh_alloc_if.sv ====
`timescale 1ns/1ps
`default_nettype none

// one of these per output, bit i always belongs to input i
interface wh_alloc_if
   import wh_router_pkg::*;
();

   // input i has a header at its fifo head routed here
   dirs_t reqs;
   // input i sent its last flit on the previous cycle
   // (release is a keyword, hence the plural)
   dirs_t releases;
   // head of fifo i holds a flit
   dirs_t valid;
   // output pops the head of fifo i
   dirs_t yumi;

   // allocator view
   modport out_ctrl (
      input  reqs,
      input  releases,
      input  valid,
      output yumi
   );

   // input view, mirror of the above
   modport in_side (
      output reqs,
      output releases,
      output valid,
      input  yumi
   );

endinterface

`default_nettype wire

// ==== logic/wh_router_pkg.sv ====
`default_nettype none

package wh_router_pkg;

   // local, west and east
   localparam int num_dirs_c = 3;

   // one bit per direction with the local port at the LSB
   typedef logic [num_dirs_c-1:0] dirs_t;

   // the east literal is dir_east since dir_e names the type
   typedef enum logic [1:0] {
      dir_p    = 2'd0,
      dir_w    = 2'd1,
      dir_east = 2'd2
   } dir_e;

   // 1-D node coordinate
   typedef logic [3:0] cord_t;

   // body flits following the header where zero means header only
   typedef logic [3:0] len_t;

   typedef logic [15:0] flit_t;

   // header field positions with payload above len
   localparam int cord_lsb_c = 0;
   localparam int len_lsb_c  = 4;

   // input controller is either waiting for a header or streaming a body
   typedef enum logic {
      ictl_idle = 1'b0,
      ictl_busy = 1'b1
   } ictl_state_e;

   function automatic cord_t hdr_cord(input flit_t flit);
      return flit[cord_lsb_c +: $bits(cord_t)];
   endfunction

   function automatic len_t hdr_len(input flit_t flit);
      return flit[len_lsb_c +: $bits(len_t)];
   endfunction

endpackage

`default_nettype wire
